// ==== hw/pack_types_pkg.sv ====
`default_nettype none

package pack_types_pkg;

   // word width of the input and output streams
   localparam int DATA_W = 21;

   // bit FIFO holds up to two full words
   localparam int BIT_CAP = 2 * DATA_W;

   localparam int WIDTH_W = $clog2(DATA_W) + 1;
   localparam int LEVEL_W = $clog2(BIT_CAP) + 1;

   // one data word
   typedef logic [DATA_W-1:0] data_t;

   // field or pop width, 0 to DATA_W
   typedef logic [WIDTH_W-1:0] width_t;

   // bit FIFO fill or free level, 0 to BIT_CAP
   typedef logic [LEVEL_W-1:0] level_t;

endpackage

`default_nettype wire

// ==== hw/pack_stream_pkg.sv ====
`default_nettype none

package pack_stream_pkg;

   // static packer configuration, sampled during reset
   typedef struct packed {
      logic                   wrap;
      pack_types_pkg::width_t width;
   } pack_cfg_t;

   // read side of a word FIFO
   // ready means the FIFO holds at least one word
   typedef struct packed {
      logic                  ready;
      pack_types_pkg::data_t data;
   } fifo_rd_t;

endpackage

`default_nettype wire

// ==== hw/word_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module word_fifo #(
   parameter int DEPTH_LOG2 = 2
) (
   input  logic                     clk_i,
   input  logic                     reset_i,
   // write side
   input  logic                     wr_i,
   input  pack_types_pkg::data_t    wdata_i,
   output logic                     not_full_o,
   // read side, first word falls through
   input  logic                     rd_i,
   output pack_stream_pkg::fifo_rd_t rd_o
);
   pack_types_pkg::data_t mem [2**DEPTH_LOG2];

   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  do_wr;
   logic                  do_rd;

   // top count bit set only when full
   assign not_full_o = ~count[DEPTH_LOG2];
   assign rd_o.ready = (count != '0);
   assign rd_o.data  = mem[rd_ptr];

   assign do_wr = wr_i & not_full_o;
   assign do_rd = rd_i & rd_o.ready;

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // simultaneous read and write leaves the count alone
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hw/bit_fifo.sv ====
`timescale 1ns/10ps
`default_nettype none

module bit_fifo (
   input  logic                   clk_i,
   input  logic                   reset_i,
   // push side, appends above the current fill
   input  logic                   push_i,
   input  pack_types_pkg::width_t push_width_i,
   input  pack_types_pkg::data_t  push_data_i,
   output pack_types_pkg::level_t push_level_o,
   // pop side, removes from the bottom
   input  logic                   pop_i,
   input  pack_types_pkg::width_t pop_width_i,
   output pack_types_pkg::data_t  pop_data_o,
   output pack_types_pkg::level_t pop_level_o
);
   logic [pack_types_pkg::BIT_CAP-1:0] buf_q;
   logic [pack_types_pkg::BIT_CAP-1:0] buf_popped;
   logic [pack_types_pkg::BIT_CAP-1:0] buf_next;
   logic [pack_types_pkg::BIT_CAP-1:0] keep_mask;
   logic [pack_types_pkg::BIT_CAP-1:0] push_ext;
   pack_types_pkg::level_t             fill_q;
   pack_types_pkg::level_t             fill_popped;
   pack_types_pkg::level_t             fill_next;
   pack_types_pkg::data_t              push_masked;

   // ones in the low w bits of a word
   function automatic pack_types_pkg::data_t field_mask(input pack_types_pkg::width_t w);
      return ~({pack_types_pkg::DATA_W{1'b1}} << w);
   endfunction

   assign pop_level_o  = fill_q;
   assign push_level_o = pack_types_pkg::level_t'(pack_types_pkg::BIT_CAP) - fill_q;

   // head bits, upper bits cleared
   assign pop_data_o  = buf_q[pack_types_pkg::DATA_W-1:0] & field_mask(pop_width_i);
   assign push_masked = push_data_i & field_mask(push_width_i);

   always_comb begin
      buf_popped  = buf_q;
      fill_popped = fill_q;
      if (pop_i) begin
         buf_popped  = buf_q >> pop_width_i;
         fill_popped = fill_q - pack_types_pkg::level_t'(pop_width_i);
      end

      // drop anything above the valid fill before appending
      keep_mask = ~({pack_types_pkg::BIT_CAP{1'b1}} << fill_popped);
      push_ext  = {{(pack_types_pkg::BIT_CAP - pack_types_pkg::DATA_W){1'b0}}, push_masked}
                  << fill_popped;

      buf_next  = buf_popped & keep_mask;
      fill_next = fill_popped;
      if (push_i) begin
         buf_next  = buf_next | push_ext;
         fill_next = fill_popped + pack_types_pkg::level_t'(push_width_i);
      end
   end

   always_ff @(posedge clk_i) begin
      buf_q <= buf_next;
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fill_q <= '0;
      end else begin
         fill_q <= fill_next;
      end
   end

endmodule

`default_nettype wire

// ==== hw/bit_packer.sv ====
`timescale 1ns/10ps
`default_nettype none

module bit_packer (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  pack_stream_pkg::pack_cfg_t cfg_i,
   // input word FIFO
   input  pack_stream_pkg::fifo_rd_t  rd_i,
   output logic                      read_o,
   // output word FIFO
   output logic                      write_o,
   input  logic                      wready_i,
   output pack_types_pkg::data_t     wdata_o
);
   typedef enum logic [1:0] {
      STEP_ACC  = 2'd0,
      STEP_READ = 2'd1,
      STEP_PUSH = 2'd2,
      STEP_POP  = 2'd3
   } step_t;

   step_t                      step_q;
   step_t                      step_next;
   pack_stream_pkg::pack_cfg_t cfg_q;
   pack_types_pkg::width_t     wrap_acc_q;
   pack_types_pkg::width_t     wrap_acc_next;
   pack_types_pkg::width_t     acc_sum;
   pack_types_pkg::width_t     pop_width;
   pack_types_pkg::data_t      word_q;
   pack_types_pkg::level_t     push_level;
   pack_types_pkg::level_t     pop_level;
   logic                       push;
   logic                       pop;

   assign pop_width = cfg_q.wrap ? wrap_acc_q
                                 : pack_types_pkg::width_t'(pack_types_pkg::DATA_W);
   assign acc_sum   = wrap_acc_q + cfg_q.width;
   assign write_o   = pop;

   always_comb begin
      read_o        = 1'b0;
      push          = 1'b0;
      pop           = 1'b0;
      wrap_acc_next = wrap_acc_q;
      step_next     = step_t'(step_q + 2'd1);

      case (step_q)
         STEP_ACC: begin
            // one field per cycle until the next would overflow the word
            if (cfg_q.wrap && (cfg_q.width != '0)
                && (acc_sum <= pack_types_pkg::width_t'(pack_types_pkg::DATA_W))) begin
               wrap_acc_next = acc_sum;
               step_next     = STEP_ACC;
            end
         end
         STEP_READ: begin
            if (rd_i.ready && (push_level >= pack_types_pkg::level_t'(cfg_q.width))) begin
               read_o = 1'b1;
            end else begin
               step_next = STEP_POP;
            end
         end
         STEP_PUSH: begin
            push = 1'b1;
         end
         default: begin
            if ((pop_level >= pack_types_pkg::level_t'(pop_width)) && wready_i) begin
               pop = 1'b1;
            end
            step_next = STEP_READ;
         end
      endcase
   end

   // head word is captured here since the FIFO advances on read
   always_ff @(posedge clk_i) begin
      if (read_o) begin
         word_q <= rd_i.data;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         step_q     <= STEP_ACC;
         wrap_acc_q <= '0;
         // config only sampled while in reset
         cfg_q      <= cfg_i;
      end else begin
         step_q     <= step_next;
         wrap_acc_q <= wrap_acc_next;
      end
   end

   bit_fifo u_bit_fifo (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .push_i      (push),
      .push_width_i(cfg_q.width),
      .push_data_i (word_q),
      .push_level_o(push_level),
      .pop_i       (pop),
      .pop_width_i (pop_width),
      .pop_data_o  (wdata_o),
      .pop_level_o (pop_level)
   );

endmodule

`default_nettype wire

// ==== hw/packer_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module packer_top (
   input  logic                      clk_i,
   input  logic                      reset_i,
   input  pack_stream_pkg::pack_cfg_t cfg_i,
   // input stream
   input  logic                      in_valid_i,
   input  pack_types_pkg::data_t     in_data_i,
   output logic                      in_ready_o,
   // output stream
   output logic                      out_valid_o,
   output pack_types_pkg::data_t     out_data_o,
   input  logic                      out_ready_i
);
   pack_stream_pkg::fifo_rd_t in_rd;
   pack_stream_pkg::fifo_rd_t out_rd;
   pack_types_pkg::data_t     packed_word;
   logic                      packer_read;
   logic                      packer_write;
   logic                      out_not_full;

   assign out_valid_o = out_rd.ready;
   assign out_data_o  = out_rd.data;

   word_fifo u_in_fifo (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .wr_i      (in_valid_i),
      .wdata_i   (in_data_i),
      .not_full_o(in_ready_o),
      .rd_i      (packer_read),
      .rd_o      (in_rd)
   );

   bit_packer u_packer (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .cfg_i   (cfg_i),
      .rd_i    (in_rd),
      .read_o  (packer_read),
      .write_o (packer_write),
      .wready_i(out_not_full),
      .wdata_o (packed_word)
   );

   word_fifo u_out_fifo (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .wr_i      (packer_write),
      .wdata_i   (packed_word),
      .not_full_o(out_not_full),
      .rd_i      (out_ready_i),
      .rd_o      (out_rd)
   );

endmodule

`default_nettype wire

// ==== test/packer_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module packer_asserts (
   input logic                       clk_i,
   input logic                       reset_i,
   input pack_stream_pkg::pack_cfg_t cfg_i,
   input logic                       in_ready_i,
   input logic                       out_valid_i,
   input pack_types_pkg::data_t      out_data_i,
   input logic                       out_ready_i
);
   pack_stream_pkg::pack_cfg_t cfg_q;
   pack_types_pkg::data_t      upper_mask;
   int                         pop_w;
   int                         fail_count = 0;

   // config as the packer sees it
   always @(posedge clk_i) begin
      if (reset_i) begin
         cfg_q <= cfg_i;
      end
   end

   always_comb begin
      pop_w = pack_types_pkg::DATA_W;
      if (cfg_q.width != '0) begin
         pop_w = (pack_types_pkg::DATA_W / int'(cfg_q.width)) * int'(cfg_q.width);
      end
      upper_mask = {pack_types_pkg::DATA_W{1'b1}} << pop_w;
   end

   // stalled output word holds
   out_stable_a : assert property (@(posedge clk_i) disable iff (reset_i)
      out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i))
      else begin
         fail_count++;
         $error("output word changed while stalled");
      end

   // clean state right after reset release
   reset_state_a : assert property (@(posedge clk_i)
      $fell(reset_i) |-> !out_valid_i && in_ready_i)
      else begin
         fail_count++;
         $error("wrong handshake state after reset");
      end

   // nothing above the whole fields in wrap mode
   wrap_zero_a : assert property (@(posedge clk_i) disable iff (reset_i)
      out_valid_i && cfg_q.wrap && (cfg_q.width != '0) |-> (out_data_i & upper_mask) == '0)
      else begin
         fail_count++;
         $error("bits set above the pop width");
      end

endmodule

`default_nettype wire

// ==== test/tb_clkgen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS = 10
) (
   output logic clk_o
);
   // free running, starts low
   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

endmodule

`default_nettype wire

// ==== test/tb_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_checker (
   input  logic                       clk_i,
   input  logic                       reset_i,
   input  pack_stream_pkg::pack_cfg_t cfg_i,
   // input handshake of the DUT
   input  logic                       in_valid_i,
   input  pack_types_pkg::data_t      in_data_i,
   input  logic                       in_ready_i,
   // output handshake of the DUT
   input  logic                       out_valid_i,
   input  pack_types_pkg::data_t      out_data_i,
   input  logic                       out_ready_i,
   output int                         exp_count_o,
   output int                         out_count_o,
   output int                         err_count_o,
   output logic                       stall_seen_o
);
   pack_stream_pkg::pack_cfg_t cfg_q;
   bit                         stream_q[$];
   pack_types_pkg::data_t      exp_q[$];
   pack_types_pkg::data_t      word;
   pack_types_pkg::data_t      exp_word;
   int                         sw;

   // bits per output word, whole fields only in wrap mode
   function automatic int slice_width(input pack_stream_pkg::pack_cfg_t cfg);
      if (cfg.wrap && (cfg.width != '0)) begin
         return (pack_types_pkg::DATA_W / int'(cfg.width)) * int'(cfg.width);
      end
      return pack_types_pkg::DATA_W;
   endfunction

   initial begin
      err_count_o  = 0;
      exp_count_o  = 0;
      out_count_o  = 0;
      stall_seen_o = 1'b0;
   end

   always @(posedge clk_i) begin
      if (reset_i) begin
         cfg_q = cfg_i;
         stream_q.delete();
         exp_q.delete();
         exp_count_o  = 0;
         out_count_o  = 0;
         stall_seen_o = 1'b0;
      end else begin
         if (!in_ready_i) begin
            stall_seen_o = 1'b1;
         end
         // append the valid field lsb first, then cut whole words
         if (in_valid_i && in_ready_i) begin
            for (int i = 0; i < int'(cfg_q.width); i++) begin
               stream_q.push_back(in_data_i[i]);
            end
            sw = slice_width(cfg_q);
            while (stream_q.size() >= sw) begin
               word = '0;
               for (int i = 0; i < sw; i++) begin
                  word[i] = stream_q.pop_front();
               end
               exp_q.push_back(word);
               exp_count_o = exp_count_o + 1;
            end
         end
         if (out_valid_i && out_ready_i) begin
            out_count_o = out_count_o + 1;
            if (exp_q.size() == 0) begin
               $display("unexpected output word %h at %0t, the model has no word pending",
                        out_data_i, $time);
               err_count_o = err_count_o + 1;
            end else begin
               exp_word = exp_q.pop_front();
               if (out_data_i !== exp_word) begin
                  $display("CHECK FAILED at %0t: out_data_o expected %h actual %h",
                           $time, exp_word, out_data_i);
                  err_count_o = err_count_o + 1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== test/tb_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_top;
   localparam logic [31:0] LCG_SEED      = 32'hff12_4cc3;
   // long enough for a surplus word to reach the output
   localparam int          SETTLE_CYCLES = 20;

   logic                       clk;
   logic                       reset;
   pack_stream_pkg::pack_cfg_t cfg;
   logic                       in_valid;
   pack_types_pkg::data_t      in_data;
   logic                       in_ready;
   logic                       out_valid;
   pack_types_pkg::data_t      out_data;
   logic                       out_ready;
   int                         exp_count;
   int                         out_count;
   int                         chk_errors;
   logic                       stall_seen;
   int                         case_width[$];
   int                         case_wrap[$];
   int                         case_n[$];
   int                         case_stall[$];
   int                         case_exp[$];
   int                         setup_errors = 0;
   int                         passed = 0;
   int                         failed = 0;
   int                         cur_test = 0;
   int                         cycle_count = 0;
   int                         cycle_limit = 0;
   logic [31:0]                data_state = LCG_SEED;
   logic [31:0]                ready_state = LCG_SEED;
   logic                       stall_mode = 1'b0;

   tb_clkgen #(.PERIOD_NS(10)) u_clkgen (.clk_o(clk));

   packer_top u_dut (
      .clk_i      (clk),
      .reset_i    (reset),
      .cfg_i      (cfg),
      .in_valid_i (in_valid),
      .in_data_i  (in_data),
      .in_ready_o (in_ready),
      .out_valid_o(out_valid),
      .out_data_o (out_data),
      .out_ready_i(out_ready)
   );

   tb_checker u_checker (
      .clk_i       (clk),
      .reset_i     (reset),
      .cfg_i       (cfg),
      .in_valid_i  (in_valid),
      .in_data_i   (in_data),
      .in_ready_i  (in_ready),
      .out_valid_i (out_valid),
      .out_data_i  (out_data),
      .out_ready_i (out_ready),
      .exp_count_o (exp_count),
      .out_count_o (out_count),
      .err_count_o (chk_errors),
      .stall_seen_o(stall_seen)
   );

   bind packer_top packer_asserts u_asserts (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .cfg_i      (cfg_i),
      .in_ready_i (in_ready_o),
      .out_valid_i(out_valid_o),
      .out_data_i (out_data_o),
      .out_ready_i(out_ready_i)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic read_cases();
      int    fd;
      int    got;
      int    w;
      int    wr;
      int    n;
      int    st;
      int    ex;
      string line;

      fd = $fopen("test/pack_cases.txt", "r");
      if (fd == 0) begin
         $display("cannot open test/pack_cases.txt");
         setup_errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line[0] == "#") begin
            continue;
         end
         got = $sscanf(line, "%d %d %d %d %d", w, wr, n, st, ex);
         if (got == 5) begin
            case_width.push_back(w);
            case_wrap.push_back(wr);
            case_n.push_back(n);
            case_stall.push_back(st);
            case_exp.push_back(ex);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_case(input int idx);
      int   sent;
      int   chk_before;
      int   asrt_before;
      logic will_accept;
      logic ok;

      cur_test    = idx;
      chk_before  = chk_errors;
      asrt_before = u_dut.u_asserts.fail_count;
      ok          = 1'b1;
      // same input words in every test, so a stalled run repeats its unstalled twin
      data_state  = LCG_SEED;
      @(posedge clk);
      stall_mode = (case_stall[idx] != 0);
      @(negedge clk);
      reset     = 1'b1;
      cfg.wrap  = (case_wrap[idx] != 0);
      cfg.width = pack_types_pkg::width_t'(case_width[idx]);
      repeat (2) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      if (out_valid !== 1'b0) begin
         $display("CHECK FAILED at %0t: out_valid_o expected 0 actual %b", $time, out_valid);
         ok = 1'b0;
      end
      if (in_ready !== 1'b1) begin
         $display("CHECK FAILED at %0t: in_ready_o expected 1 actual %b", $time, in_ready);
         ok = 1'b0;
      end
      // ready seen at a falling edge holds through the next rising edge
      sent = 0;
      while (sent < case_n[idx]) begin
         data_state = lcg_next(data_state);
         in_valid   = 1'b1;
         in_data    = data_state[31:11];
         do begin
            will_accept = in_ready;
            @(negedge clk);
         end while (!will_accept);
         sent++;
      end
      in_valid = 1'b0;
      while (out_count < case_exp[idx]) begin
         @(negedge clk);
      end
      repeat (SETTLE_CYCLES) @(negedge clk);
      if (out_count != case_exp[idx]) begin
         $display("CHECK FAILED at %0t: output word count expected %0d actual %0d",
                  $time, case_exp[idx], out_count);
         ok = 1'b0;
      end
      if (exp_count != case_exp[idx]) begin
         $display("CHECK FAILED at %0t: model word count expected %0d actual %0d",
                  $time, case_exp[idx], exp_count);
         ok = 1'b0;
      end
      if (case_stall[idx] != 0 && !stall_seen) begin
         $display("in_ready_o never dropped during test %0d", idx);
         ok = 1'b0;
      end
      if (chk_errors != chk_before || u_dut.u_asserts.fail_count != asrt_before) begin
         ok = 1'b0;
      end
      $display("test %0d: width %0d wrap %0d n %0d stall %0d words %0d/%0d %s", idx,
               case_width[idx], case_wrap[idx], case_n[idx], case_stall[idx],
               out_count, case_exp[idx], ok ? "pass" : "FAIL");
      if (ok) begin
         passed++;
      end else begin
         failed++;
      end
   endtask

   // random back-pressure only in stall mode
   always @(negedge clk) begin
      if (stall_mode) begin
         ready_state = lcg_next(ready_state);
         out_ready   = ready_state[31];
      end else begin
         out_ready = 1'b1;
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("timeout: test %0d hung, run did not end within %0d cycles",
                  cur_test, cycle_limit);
         $display("Finished with errors");
         $finish;
      end
   end

   initial begin
      reset     = 1'b1;
      cfg       = '0;
      in_valid  = 1'b0;
      in_data   = '0;
      out_ready = 1'b1;
      read_cases();
      if (case_n.size() == 0) begin
         $display("no test cases read from test/pack_cases.txt");
         setup_errors++;
      end
      foreach (case_n[i]) begin
         cycle_limit += 8 * case_n[i] + 50;
      end
      foreach (case_n[i]) begin
         run_case(i);
      end
      $display("tests passed %0d failed %0d", passed, failed);
      if (failed == 0 && setup_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== test/pack_cases.txt ====
# columns: width wrap n stall expected_words (decimal)
# stall 1 drives out_ready_i from the LCG
5 0 40 0 9
8 0 30 0 11
13 0 25 0 15
4 1 30 0 6
6 1 31 0 10
10 1 25 0 12
7 1 22 0 7
21 0 20 0 20
21 1 12 0 12
8 0 30 1 11
6 1 31 1 10
21 0 20 1 20
3 0 50 1 7

// ==== vlog.f ====
hw/pack_types_pkg.sv
hw/pack_stream_pkg.sv
hw/word_fifo.sv
hw/bit_fifo.sv
hw/bit_packer.sv
hw/packer_top.sv
test/packer_asserts.sv
test/tb_clkgen.sv
test/tb_checker.sv
test/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || \
	   ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
